//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_sram_io_ctrl
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "No pass message found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/frame_shifter.sv
`timescale 1ns/10ps

module frame_shifter (
    input  logic                     csi_clk,
    input  logic                     rsi_reset_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  sio_link_pkg::xfer_req_t  req,
    input  logic                     rise_tick,
    input  logic                     fall_tick,
    input  logic                     so,
    output logic                     si,
    output logic                     ctrl_load,
    output logic                     busy,
    output logic                     rsp_valid,
    output sio_link_pkg::xfer_rsp_t  rsp
);

    import sio_link_pkg::*;

    localparam int CNT_WIDTH = $clog2(FRAME_BITS + 1);

    shift_state_e           state;
    logic [FRAME_BITS-1:0]  shreg;       // Outgoing bits low, incoming bits high
    logic [CNT_WIDTH-1:0]   rise_cnt;
    logic                   load_q;
    logic                   so_q;        // Sample from the last rise
    frame_dir_e             dir_q;
    logic                   req_fire;
    logic                   shift_fall;
    logic                   last_rise;

    assign req_ready = (state == ST_IDLE);
    assign req_fire  = req_valid && req_ready;

    // A pending request counts as busy so the host never sees a gap
    assign busy = req_valid || (state != ST_IDLE);

    assign si        = shreg[0];
    assign ctrl_load = load_q;

    assign shift_fall = (state == ST_SHIFT) && fall_tick;
    assign last_rise  = (state == ST_SHIFT) && rise_tick
                        && (rise_cnt == CNT_WIDTH'(FRAME_BITS - 1));

    // --------------------------------------------------
    // Frame FSM
    // --------------------------------------------------

    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            state     <= ST_IDLE;
            load_q    <= 1'b0;
            rise_cnt  <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (req_valid)
                    begin
                        state    <= ST_ARM;
                        rise_cnt <= '0;
                    end
                end
                ST_ARM:
                begin
                    // Load goes up with the chip clock fall
                    if (fall_tick)
                    begin
                        state  <= ST_SHIFT;
                        load_q <= 1'b1;
                    end
                end
                ST_SHIFT:
                begin
                    if (fall_tick)
                        load_q <= 1'b0;    // One full chip clock period
                    if (rise_tick)
                        rise_cnt <= rise_cnt + 1'b1;
                    if (last_rise)
                    begin
                        state     <= ST_IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Shift register
    // --------------------------------------------------

    // Drives the si pin, so it starts from a known level
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
            shreg <= '0;
        else if (req_fire)
            shreg <= (req.dir == DIR_TO_CHIP) ? {req.addr, req.data} : '0;
        else if (shift_fall)
            shreg <= {so_q, shreg[FRAME_BITS-1:1]};    // Next bit out, last sample in
    end

    always_ff @(posedge csi_clk)
    begin
        if (req_fire)
            dir_q <= req.dir;
        if (rise_tick)
            so_q <= so;
        // Final sample is taken straight from the pin
        if (last_rise)
        begin
            rsp.dir             <= dir_q;
            {rsp.addr, rsp.data} <= {so, shreg[FRAME_BITS-1:1]};
        end
    end

    assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        ctrl_load |-> (state != ST_IDLE));

endmodule

//--- design/host_reg_file.sv
`timescale 1ns/10ps

module host_reg_file #(
    parameter int DIV_WIDTH   = 8,
    parameter int DEFAULT_DIV = 0
) (
    input  logic                     csi_clk,
    input  logic                     rsi_reset_n,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  sio_host_pkg::host_cmd_t  cmd,
    output logic [DIV_WIDTH-1:0]     div_value,
    output logic                     req_valid,
    input  logic                     req_ready,
    output sio_link_pkg::xfer_req_t  req,
    output logic                     ctrl_bgn,
    output logic                     ctrl_mod0,
    output logic                     ctrl_mod1,
    output logic                     chip_rst_n
);

    import sio_host_pkg::*;
    import sio_link_pkg::*;

    logic                       cmd_fire;
    logic [1:0]                 mode_q;      // {mod1, mod0}
    logic [1:0]                 new_mode;
    logic                       load_hit;
    logic [MEM_ADDR_WIDTH-1:0]  addr_q;
    logic [MEM_DATA_WIDTH-1:0]  data_q;

    // Stall the host only while a request waits for the shifter
    assign cmd_ready = !req_valid || req_ready;
    assign cmd_fire  = cmd_valid && cmd_ready;

    assign new_mode = {cmd.payload[CTRL_MOD1_BIT], cmd.payload[CTRL_MOD0_BIT]};

    // Only modes 00 and 10 move a frame over the serial link
    assign load_hit = cmd_fire && (cmd.op == OP_CTRL) && cmd.payload[CTRL_LOAD_BIT]
                      && ((new_mode == 2'b00) || (new_mode == 2'b10));

    assign ctrl_mod0 = mode_q[0];
    assign ctrl_mod1 = mode_q[0] ? mode_q[1] : 1'b0;    // Masked unless mod0 set

    // --------------------------------------------------
    // Control and divider registers
    // --------------------------------------------------

    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            ctrl_bgn   <= 1'b0;
            chip_rst_n <= 1'b0;    // Chip held in reset until the host releases it
            mode_q     <= 2'b00;
            div_value  <= DIV_WIDTH'(DEFAULT_DIV);
        end
        else if (cmd_fire)
        begin
            if (cmd.op == OP_CTRL)
            begin
                ctrl_bgn   <= cmd.payload[CTRL_BGN_BIT];
                chip_rst_n <= cmd.payload[CTRL_RST_N_BIT];
                mode_q     <= new_mode;
            end
            else if (cmd.op == OP_DIV)
            begin
                div_value <= cmd.payload[DIV_WIDTH-1:0];
            end
        end
    end

    // SRAM address and data words, plus the frame snapshot
    always_ff @(posedge csi_clk)
    begin
        if (cmd_fire && (cmd.op == OP_ADDR))
            addr_q <= cmd.payload[MEM_ADDR_WIDTH-1:0];
        if (cmd_fire && (cmd.op == OP_DATA))
            data_q <= cmd.payload[MEM_DATA_WIDTH-1:0];
        if (load_hit)
        begin
            req.dir  <= new_mode[1] ? DIR_FROM_CHIP : DIR_TO_CHIP;
            req.addr <= addr_q;
            req.data <= data_q;
        end
    end

    // --------------------------------------------------
    // Request handshake
    // --------------------------------------------------

    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
            req_valid <= 1'b0;
        else if (load_hit)
            req_valid <= 1'b1;    // A new load wins over the acceptance
        else if (req_ready)
            req_valid <= 1'b0;
    end

    // A stalled request keeps its fields until the shifter takes it
    assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)));

endmodule

//--- design/readback_stage.sv
`timescale 1ns/10ps

module readback_stage (
    input  logic                                 csi_clk,
    input  logic                                 rsi_reset_n,
    input  logic                                 rsp_valid,
    input  sio_link_pkg::xfer_rsp_t              rsp,
    input  logic                                 busy,
    input  logic                                 ctrl_rdy,
    input  logic                                 nxt_end,
    input  logic                                 nxt_cont,
    input  logic                                 so,
    output logic [sio_host_pkg::AVS_WIDTH-1:0]   stat_readdata,
    output logic [sio_host_pkg::AVS_WIDTH-1:0]   addr_readdata,
    output logic [sio_host_pkg::AVS_WIDTH-1:0]   data_readdata
);

    import sio_host_pkg::*;
    import sio_link_pkg::*;

    logic [MEM_ADDR_WIDTH-1:0]  addr_q;
    logic [MEM_DATA_WIDTH-1:0]  data_q;
    logic [AVS_WIDTH-1:0]       stat_next;

    always_comb
    begin
        stat_next                    = '0;
        stat_next[STAT_RDY_BIT]      = ctrl_rdy;
        stat_next[STAT_NXT_END_BIT]  = nxt_end;
        stat_next[STAT_NXT_CONT_BIT] = nxt_cont;
        stat_next[STAT_SO_BIT]       = so;
        stat_next[STAT_BUSY_BIT]     = busy;
    end

    // Status also samples the chip pins into csi_clk, busy drops with the new words
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            addr_q        <= '0;
            data_q        <= '0;
            stat_readdata <= '0;
        end
        else
        begin
            stat_readdata <= stat_next;
            if (rsp_valid && (rsp.dir == DIR_FROM_CHIP))
            begin
                addr_q <= rsp.addr;
                data_q <= rsp.data;
            end
        end
    end

    assign addr_readdata = {{(AVS_WIDTH - MEM_ADDR_WIDTH){1'b0}}, addr_q};
    assign data_readdata = {{(AVS_WIDTH - MEM_DATA_WIDTH){1'b0}}, data_q};

endmodule

//--- design/sclk_divider.sv
`timescale 1ns/10ps

module sclk_divider #(
    parameter int DIV_WIDTH = 8
) (
    input  logic                  csi_clk,
    input  logic                  rsi_reset_n,
    input  logic [DIV_WIDTH-1:0]  div_value,
    output logic                  chip_clk,
    output logic                  rise_tick,
    output logic                  fall_tick
);

    logic [DIV_WIDTH-1:0]  half_cnt;
    logic                  half_done;

    // Greater-or-equal so a smaller divider never makes the count wrap
    assign half_done = (half_cnt >= div_value);

    // Ticks mark the cycle whose closing edge toggles chip_clk
    assign rise_tick = half_done && !chip_clk;
    assign fall_tick = half_done && chip_clk;

    // --------------------------------------------------
    // Half-period counter
    // --------------------------------------------------

    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            half_cnt <= '0;
            chip_clk <= 1'b0;
        end
        else if (half_done)
        begin
            half_cnt <= '0;
            chip_clk <= ~chip_clk;
        end
        else
        begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        !(rise_tick && fall_tick));

endmodule

//--- design/sio_host_pkg.sv
package sio_host_pkg;

    // --------------------------------------------------
    // Host command channel
    // --------------------------------------------------

    localparam int AVS_WIDTH = 32;    // Host payload and readback word width

    // Register selected by a host command
    typedef enum logic [1:0] {
        OP_CTRL = 2'd0,    // Control word
        OP_ADDR = 2'd1,    // SRAM address
        OP_DATA = 2'd2,    // SRAM data
        OP_DIV  = 2'd3     // Serial clock divider
    } host_op_e;

    typedef struct packed {
        host_op_e               op;
        logic [AVS_WIDTH-1:0]   payload;
    } host_cmd_t;

    // --------------------------------------------------
    // Control word fields
    // --------------------------------------------------

    localparam int CTRL_BGN_BIT   = 0;
    localparam int CTRL_LOAD_BIT  = 1;    // Starts a frame, not stored
    localparam int CTRL_MOD0_BIT  = 2;
    localparam int CTRL_MOD1_BIT  = 3;
    localparam int CTRL_RST_N_BIT = 6;

    // --------------------------------------------------
    // Status word fields
    // --------------------------------------------------

    localparam int STAT_RDY_BIT      = 0;
    localparam int STAT_NXT_END_BIT  = 1;
    localparam int STAT_NXT_CONT_BIT = 2;
    localparam int STAT_SO_BIT       = 4;    // Raw serial-out pin
    localparam int STAT_BUSY_BIT     = 5;

endpackage

//--- design/sio_link_pkg.sv
package sio_link_pkg;

    // --------------------------------------------------
    // Serial frame layout
    // --------------------------------------------------

    localparam int MEM_ADDR_WIDTH = 10;
    localparam int MEM_DATA_WIDTH = 8;

    // Address sits above data, bit 0 goes out first
    localparam int FRAME_BITS = MEM_ADDR_WIDTH + MEM_DATA_WIDTH;

    typedef enum logic {
        DIR_TO_CHIP   = 1'b0,    // Mode 00
        DIR_FROM_CHIP = 1'b1     // Mode 10
    } frame_dir_e;

    // Frame request from the register file
    typedef struct packed {
        frame_dir_e                 dir;
        logic [MEM_ADDR_WIDTH-1:0]  addr;
        logic [MEM_DATA_WIDTH-1:0]  data;
    } xfer_req_t;

    // Completed frame, addr and data hold the bits read from the chip
    typedef struct packed {
        frame_dir_e                 dir;
        logic [MEM_ADDR_WIDTH-1:0]  addr;
        logic [MEM_DATA_WIDTH-1:0]  data;
    } xfer_rsp_t;

    // --------------------------------------------------
    // Shifter FSM
    // --------------------------------------------------

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ARM   = 2'd1,    // Waiting for a chip clock fall
        ST_SHIFT = 2'd2
    } shift_state_e;

endpackage

//--- design/sram_io_ctrl.sv
`timescale 1ns/10ps

module sram_io_ctrl #(
    parameter int DIV_WIDTH   = 8,
    parameter int DEFAULT_DIV = 0    // 0 gives half the csi_clk rate
) (
    input  logic                                csi_clk,
    input  logic                                rsi_reset_n,
    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    input  sio_host_pkg::host_cmd_t             cmd,
    output logic [sio_host_pkg::AVS_WIDTH-1:0]  stat_readdata,
    output logic [sio_host_pkg::AVS_WIDTH-1:0]  addr_readdata,
    output logic [sio_host_pkg::AVS_WIDTH-1:0]  data_readdata,
    output logic                                chip_clk,
    output logic                                ctrl_load,
    output logic                                si,
    output logic                                ctrl_bgn,
    output logic                                ctrl_mod0,
    output logic                                ctrl_mod1,
    output logic                                chip_rst_n,
    input  logic                                so,
    input  logic                                ctrl_rdy,
    input  logic                                nxt_end,
    input  logic                                nxt_cont
);

    import sio_link_pkg::*;

    logic [DIV_WIDTH-1:0]  div_value;
    logic                  req_valid;
    logic                  req_ready;
    xfer_req_t             req;
    logic                  rise_tick;
    logic                  fall_tick;
    logic                  busy;
    logic                  rsp_valid;
    xfer_rsp_t             rsp;

    // --------------------------------------------------
    // Pipeline stages
    // --------------------------------------------------

    host_reg_file #(
        .DIV_WIDTH   (DIV_WIDTH),
        .DEFAULT_DIV (DEFAULT_DIV)
    ) u_host_reg_file (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd         (cmd),
        .div_value   (div_value),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .ctrl_bgn    (ctrl_bgn),
        .ctrl_mod0   (ctrl_mod0),
        .ctrl_mod1   (ctrl_mod1),
        .chip_rst_n  (chip_rst_n)
    );

    sclk_divider #(
        .DIV_WIDTH (DIV_WIDTH)
    ) u_sclk_divider (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .div_value   (div_value),
        .chip_clk    (chip_clk),
        .rise_tick   (rise_tick),
        .fall_tick   (fall_tick)
    );

    frame_shifter u_frame_shifter (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .rise_tick   (rise_tick),
        .fall_tick   (fall_tick),
        .so          (so),
        .si          (si),
        .ctrl_load   (ctrl_load),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    readback_stage u_readback_stage (
        .csi_clk       (csi_clk),
        .rsi_reset_n   (rsi_reset_n),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .busy          (busy),
        .ctrl_rdy      (ctrl_rdy),
        .nxt_end       (nxt_end),
        .nxt_cont      (nxt_cont),
        .so            (so),
        .stat_readdata (stat_readdata),
        .addr_readdata (addr_readdata),
        .data_readdata (data_readdata)
    );

endmodule

//--- sim/tb_sram_io_ctrl.sv
`timescale 1ns/10ps

module tb_sram_io_ctrl;

    import sio_host_pkg::*;
    import sio_link_pkg::*;

    // Frame count over all phases below, and the slowest divider used
    localparam int NUM_FRAMES = 14;
    localparam int MAX_DIV    = 3;
    // Each frame is 18 chip clock periods plus arming, doubled for margin
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_BITS * 2 * (MAX_DIV + 1) * 2 + 1000;

    typedef struct packed {
        logic                       is_read;
        logic [MEM_ADDR_WIDTH-1:0]  addr;
        logic [MEM_DATA_WIDTH-1:0]  data;
    } frame_exp_t;

    logic                  csi_clk;
    logic                  rsi_reset_n;
    logic                  cmd_valid;
    logic                  cmd_ready;
    host_cmd_t             cmd;
    logic [AVS_WIDTH-1:0]  stat_readdata;
    logic [AVS_WIDTH-1:0]  addr_readdata;
    logic [AVS_WIDTH-1:0]  data_readdata;
    logic                  chip_clk;
    logic                  ctrl_load;
    logic                  si;
    logic                  ctrl_bgn;
    logic                  ctrl_mod0;
    logic                  ctrl_mod1;
    logic                  chip_rst_n;
    logic                  so;
    logic                  ctrl_rdy;
    logic                  nxt_end;
    logic                  nxt_cont;

    integer                 seed;
    int                     cycle_cnt;
    logic                   clk_seen;      // chip_clk at the previous falling csi_clk edge
    logic                   in_frame;
    logic [4:0]             bit_cnt;       // Rises seen in the current frame
    logic [FRAME_BITS-1:0]  si_bits;
    logic [FRAME_BITS-1:0]  so_word;       // Word the chip returns on read frames
    logic [FRAME_BITS-1:0]  captured_q[$];
    frame_exp_t             exp_q[$];
    frame_exp_t             last_exp;
    int                     frames_seen;
    int                     frames_checked;
    logic                   watch_busy;

    sram_io_ctrl #(
        .DIV_WIDTH   (8),
        .DEFAULT_DIV (0)
    ) u_sram_io_ctrl (.*);

    always #2 csi_clk = ~csi_clk;

    // --------------------------------------------------
    // Checking helpers
    // --------------------------------------------------

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // Address above data, frame bit 0 is the first one on the wire
    function automatic logic [FRAME_BITS-1:0] ref_frame(input logic [MEM_ADDR_WIDTH-1:0] addr,
                                                        input logic [MEM_DATA_WIDTH-1:0] data);
        return {addr, data};
    endfunction

    always @(posedge csi_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("Timeout: the run did not finish within %0d cycles", cycle_cnt));
    end

    // --------------------------------------------------
    // Chip model
    // --------------------------------------------------

    // Samples si on each chip clock rise, the first frame rise has load high
    always @(negedge csi_clk)
    begin
        if (chip_clk && !clk_seen)
        begin
            if (ctrl_load && !in_frame)
            begin
                in_frame = 1'b1;
                bit_cnt  = 5'd0;
            end
            if (in_frame)
            begin
                si_bits = {si, si_bits[FRAME_BITS-1:1]};    // LSB arrives first
                bit_cnt = bit_cnt + 5'd1;
                if (bit_cnt == 5'(FRAME_BITS))
                begin
                    captured_q.push_back(si_bits);
                    frames_seen = frames_seen + 1;
                    in_frame    = 1'b0;
                end
            end
        end
        clk_seen = chip_clk;
    end

    // Next bit goes out on the fall before the rise that samples it
    always @(negedge chip_clk)
        so <= so_word[in_frame ? bit_cnt : 5'd0];

    // Compares each captured write frame with the reference
    always @(posedge csi_clk)
    begin
        frame_exp_t             entry;
        logic [FRAME_BITS-1:0]  got;
        if (captured_q.size() > 0)
        begin
            got = captured_q.pop_front();
            if (exp_q.size() == 0)
                stop_on_error("The chip saw a frame that no load command started");
            else
            begin
                entry = exp_q.pop_front();
                if (!entry.is_read)
                    check_value("si_frame", 32'(got), 32'(ref_frame(entry.addr, entry.data)));
                frames_checked = frames_checked + 1;
            end
        end
    end

    always @(negedge csi_clk)
        if (watch_busy)
            check_value("stat_busy", 32'(stat_readdata[STAT_BUSY_BIT]), 32'd1);

    // --------------------------------------------------
    // Host side tasks
    // --------------------------------------------------

    task automatic send_cmd(input host_op_e op, input logic [AVS_WIDTH-1:0] payload);
        @(posedge csi_clk);
        cmd_valid   <= 1'b1;
        cmd.op      <= op;
        cmd.payload <= payload;
        @(negedge csi_clk);
        while (!cmd_ready)
            @(negedge csi_clk);
        @(posedge csi_clk);    // Handshake edge
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        @(negedge csi_clk);
        while (stat_readdata[STAT_BUSY_BIT] !== level)
            @(negedge csi_clk);
    endtask

    // Idle status word, so holds the first bit of the last read word
    task automatic check_status(input logic [2:0] pins);
        logic [AVS_WIDTH-1:0]  exp_stat;
        @(posedge csi_clk);
        ctrl_rdy <= pins[0];
        nxt_end  <= pins[1];
        nxt_cont <= pins[2];
        @(posedge csi_clk);    // Status register takes the new pins here
        exp_stat                    = '0;
        exp_stat[STAT_RDY_BIT]      = pins[0];
        exp_stat[STAT_NXT_END_BIT]  = pins[1];
        exp_stat[STAT_NXT_CONT_BIT] = pins[2];
        exp_stat[STAT_SO_BIT]       = so;
        @(negedge csi_clk);
        check_value("stat_readdata", stat_readdata, exp_stat);
    endtask

    task automatic start_frame(input logic is_read);
        frame_exp_t            entry;
        logic [AVS_WIDTH-1:0]  ctrl;
        entry.is_read = is_read;
        entry.addr    = MEM_ADDR_WIDTH'($random(seed));
        entry.data    = MEM_DATA_WIDTH'($random(seed));
        exp_q.push_back(entry);
        last_exp = entry;
        if (is_read)
        begin
            @(negedge csi_clk);
            so_word = ref_frame(entry.addr, entry.data);
        end
        else
        begin
            send_cmd(OP_ADDR, AVS_WIDTH'(entry.addr));
            send_cmd(OP_DATA, AVS_WIDTH'(entry.data));
        end
        ctrl                 = '0;
        ctrl[CTRL_RST_N_BIT] = 1'b1;
        ctrl[CTRL_LOAD_BIT]  = 1'b1;
        ctrl[CTRL_MOD1_BIT]  = is_read;    // Mode 10 reads, mode 00 writes
        send_cmd(OP_CTRL, ctrl);
    endtask

    task automatic run_frame(input logic is_read);
        start_frame(is_read);
        wait_busy(1'b1);
        wait_busy(1'b0);
        if (is_read)
        begin
            check_value("addr_readdata", addr_readdata, 32'(last_exp.addr));
            check_value("data_readdata", data_readdata, 32'(last_exp.data));
        end
    endtask

    // Skips the half period cut by the divider write, then measures four
    task automatic check_half_periods(input int div);
        int    len;
        logic  level;
        @(negedge csi_clk);
        level = chip_clk;
        while (chip_clk == level)
            @(negedge csi_clk);
        repeat (4)
        begin
            len   = 0;
            level = chip_clk;
            do
            begin
                @(negedge csi_clk);
                len = len + 1;
            end
            while (chip_clk == level);
            check_value("chip_clk half period", len, div + 1);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial
    begin
        logic [AVS_WIDTH-1:0]  ctrl;
        logic [1:0]            mode;
        int                    n0;
        seed           = 32'h841ed849;
        csi_clk        = 1'b0;
        rsi_reset_n    = 1'b0;
        cmd_valid      = 1'b0;
        cmd            = '0;
        so             = 1'b0;
        ctrl_rdy       = 1'b0;
        nxt_end        = 1'b0;
        nxt_cont       = 1'b0;
        so_word        = '0;
        watch_busy     = 1'b0;
        clk_seen       = 1'b0;
        in_frame       = 1'b0;
        bit_cnt        = 5'd0;
        si_bits        = '0;
        cycle_cnt      = 0;
        frames_seen    = 0;
        frames_checked = 0;

        repeat (4) @(posedge csi_clk);
        rsi_reset_n <= 1'b1;
        @(negedge csi_clk);
        check_value("ctrl_load", 32'(ctrl_load), 32'd0);
        check_value("chip_rst_n", 32'(chip_rst_n), 32'd0);
        check_value("ctrl_bgn", 32'(ctrl_bgn), 32'd0);
        check_value("ctrl_mod0", 32'(ctrl_mod0), 32'd0);
        check_value("ctrl_mod1", 32'(ctrl_mod1), 32'd0);
        check_value("addr_readdata", addr_readdata, 32'd0);
        check_value("data_readdata", data_readdata, 32'd0);
        check_value("cmd_ready", 32'(cmd_ready), 32'd1);

        // Control writes without load, mod1 shows only with mod0 set
        for (int m = 0; m < 4; m++)
        begin
            mode                = 2'(m);
            ctrl                = 32'($random(seed));
            ctrl[CTRL_LOAD_BIT] = 1'b0;
            ctrl[CTRL_MOD0_BIT] = mode[0];
            ctrl[CTRL_MOD1_BIT] = mode[1];
            send_cmd(OP_CTRL, ctrl);
            @(negedge csi_clk);
            check_value("ctrl_bgn", 32'(ctrl_bgn), 32'(ctrl[CTRL_BGN_BIT]));
            check_value("chip_rst_n", 32'(chip_rst_n), 32'(ctrl[CTRL_RST_N_BIT]));
            check_value("ctrl_mod0", 32'(ctrl_mod0), 32'(mode[0]));
            check_value("ctrl_mod1", 32'(ctrl_mod1), 32'(mode[1] & mode[0]));
        end

        send_cmd(OP_DIV, 32'd0);
        check_half_periods(0);
        repeat (4) run_frame(1'b0);
        repeat (4) run_frame(1'b1);

        // Chip status pins between frames
        repeat (4) check_status(3'($random(seed)));

        send_cmd(OP_DIV, 32'(MAX_DIV));
        check_half_periods(MAX_DIV);
        repeat (2) run_frame(1'b0);
        repeat (2) run_frame(1'b1);

        // Back-pressure, second load pends while the first frame runs
        n0 = frames_seen;
        start_frame(1'b0);
        wait_busy(1'b1);
        watch_busy = 1'b1;
        start_frame(1'b0);
        check_value("frames_seen before stall", frames_seen, n0);
        send_cmd(OP_ADDR, 32'($random(seed)));
        check_value("frames_seen at stalled accept", frames_seen, n0 + 1);
        while (frames_seen != n0 + 2)
            @(posedge csi_clk);
        watch_busy = 1'b0;
        wait_busy(1'b0);

        repeat (4) @(posedge csi_clk);
        if ((frames_checked == NUM_FRAMES) && (exp_q.size() == 0))
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            stop_on_error($sformatf("Only %0d of %0d frames reached the compare",
                                    frames_checked, NUM_FRAMES));
        end
    end

endmodule

//--- verilog.f
design/sio_host_pkg.sv
design/sio_link_pkg.sv
design/host_reg_file.sv
design/sclk_divider.sv
design/frame_shifter.sv
design/readback_stage.sv
design/sram_io_ctrl.sv
sim/tb_sram_io_ctrl.sv
